// File: verilog/mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

    typedef logic [31:0] u32_t;

    // access size code from the data client
    typedef logic [2:0] byte_type_t;

    localparam byte_type_t BT_BYTE   = 3'd0;
    localparam byte_type_t BT_HALF   = 3'd1;
    localparam byte_type_t BT_WORD   = 3'd2;
    localparam byte_type_t BT_BYTE_U = 3'd4;
    localparam byte_type_t BT_HALF_U = 3'd5;

    // one word seen whole or as byte lanes
    typedef union packed {
        u32_t            word;
        logic [3:0][7:0] bytes;
    } lane_word_u;

    typedef struct packed {
        logic [3:0] id;
        u32_t       addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    localparam logic [3:0] ID_ICACHE = 4'd0;
    localparam logic [3:0] ID_DCACHE = 4'd1;

    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;  // one beat
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;  // 4 bytes
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage

`default_nettype wire

// File: verilog/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align
    import mem_bridge_pkg::*;
(
    input  byte_type_t byte_type,
    input  logic [1:0] offset,
    input  u32_t       store_data,
    input  u32_t       load_word,
    output u32_t       store_word,
    output logic [3:0] store_strb,
    output u32_t       load_data
);

    lane_word_u src;
    lane_word_u placed;
    lane_word_u ret;

    logic [1:0] half_lo;  // lower lane of the addressed halfword
    logic [1:0] half_hi;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign src.word = store_data;
    assign ret.word = load_word;

    assign half_lo = {offset[1], 1'b0};
    assign half_hi = {offset[1], 1'b1};

    // store side: move the low bytes up to the addressed lane
    always_comb begin
        placed.word = '0;
        store_strb  = 4'b0000;
        case (byte_type)
            BT_BYTE, BT_BYTE_U: begin
                placed.bytes[offset] = src.bytes[0];
                store_strb[offset]   = 1'b1;
            end
            BT_HALF, BT_HALF_U: begin
                placed.bytes[half_lo] = src.bytes[0];
                placed.bytes[half_hi] = src.bytes[1];
                store_strb[half_lo]   = 1'b1;
                store_strb[half_hi]   = 1'b1;
            end
            default: begin  // word and unknown codes
                placed.word = src.word;
                store_strb  = 4'b1111;
            end
        endcase
    end

    assign store_word = placed.word;

    // load side: pick the lane, then extend
    assign ld_byte = ret.bytes[offset];
    assign ld_half = {ret.bytes[half_hi], ret.bytes[half_lo]};

    always_comb begin
        case (byte_type)
            BT_BYTE:   load_data = {{24{ld_byte[7]}}, ld_byte};
            BT_BYTE_U: load_data = {24'd0, ld_byte};
            BT_HALF:   load_data = {{16{ld_half[15]}}, ld_half};
            BT_HALF_U: load_data = {16'd0, ld_half};
            default:   load_data = ret.word;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uncached_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uncached_bridge
    import mem_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       icache_req_valid,
    input  u32_t       icache_pa,
    input  logic       stall_icache,
    output logic       icache_busy,
    output logic       icache_data_valid,

    input  logic       dcache_req_valid,
    input  logic       dcache_store,
    input  u32_t       dcache_pa,
    input  byte_type_t dcache_byte_type,
    input  u32_t       wr_dcache_data,
    input  logic       stall_dcache,
    output logic       dcache_busy,
    output logic       dcache_data_valid,

    output axi_ar_t    ar_chan,
    output logic       arvalid,
    input  logic       arready,
    output axi_aw_t    aw_chan,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w_chan,
    output logic       wvalid,
    input  logic       wready,
    input  logic       rvalid,
    output logic       rready,
    input  logic       bvalid,
    output logic       bready,

    // lane aligner hookup
    output byte_type_t req_byte_type,
    output logic [1:0] req_offset,
    output u32_t       store_data_raw,
    input  u32_t       store_word,
    input  logic [3:0] store_strb
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RADDR,
        S_RDATA,
        S_WADDR,
        S_WDATA,
        S_WRESP
    } state_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_ICACHE,
        OWN_DREAD,
        OWN_DWRITE
    } owner_t;

    state_t state, state_nxt;
    owner_t owner, owner_nxt;

    logic       accept;
    u32_t       sel_pa;
    u32_t       addr_q;
    byte_type_t bt_q;
    logic [1:0] off_q;
    u32_t       wdata_q;
    logic [3:0] wstrb_q;
    logic       stall_sel;

    assign accept = (state == S_IDLE) && (dcache_req_valid || icache_req_valid);
    assign sel_pa = dcache_req_valid ? dcache_pa : icache_pa;  // data wins

    // live request in idle so the placed word is ready at accept
    assign req_byte_type  = (state == S_IDLE) ? (dcache_req_valid ? dcache_byte_type : BT_WORD)
                                              : bt_q;
    assign req_offset     = (state == S_IDLE) ? (dcache_req_valid ? dcache_pa[1:0] : 2'b00)
                                              : off_q;
    assign store_data_raw = wr_dcache_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            owner <= OWN_NONE;
        end else begin
            state <= state_nxt;
            owner <= owner_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= {sel_pa[31:2], 2'b00};
            bt_q    <= req_byte_type;
            off_q   <= req_offset;
            wdata_q <= store_word;
            wstrb_q <= store_strb;
        end
    end

    assign stall_sel = (owner == OWN_ICACHE) ? stall_icache : stall_dcache;

    always_comb begin
        state_nxt = state;
        owner_nxt = owner;
        arvalid   = 1'b0;
        awvalid   = 1'b0;
        wvalid    = 1'b0;
        rready    = 1'b0;
        bready    = 1'b0;
        case (state)
            S_IDLE: begin
                if (dcache_req_valid) begin
                    if (dcache_store) begin
                        state_nxt = S_WADDR;
                        owner_nxt = OWN_DWRITE;
                    end else begin
                        state_nxt = S_RADDR;
                        owner_nxt = OWN_DREAD;
                    end
                end else if (icache_req_valid) begin
                    state_nxt = S_RADDR;
                    owner_nxt = OWN_ICACHE;
                end
            end
            S_RADDR: begin
                arvalid = 1'b1;
                if (arready) state_nxt = S_RDATA;
            end
            S_RDATA: begin
                // hold the beat at the slave while the client stalls
                if (rvalid && !stall_sel) begin
                    rready    = 1'b1;
                    state_nxt = S_IDLE;
                    owner_nxt = OWN_NONE;
                end
            end
            S_WADDR: begin
                awvalid = 1'b1;
                if (awready) state_nxt = S_WDATA;
            end
            S_WDATA: begin
                wvalid = 1'b1;
                if (wready) state_nxt = S_WRESP;
            end
            S_WRESP: begin
                bready = 1'b1;
                if (bvalid) begin
                    state_nxt = S_IDLE;
                    owner_nxt = OWN_NONE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
                owner_nxt = OWN_NONE;
            end
        endcase
    end

    assign dcache_busy = (owner != OWN_NONE);
    assign icache_busy = dcache_busy | dcache_req_valid;  // lost arbitration too

    assign icache_data_valid = rready && (owner == OWN_ICACHE);
    assign dcache_data_valid = rready && (owner == OWN_DREAD);

    assign ar_chan.id    = (owner == OWN_ICACHE) ? ID_ICACHE : ID_DCACHE;
    assign ar_chan.addr  = addr_q;
    assign ar_chan.len   = AXI_LEN_SINGLE;
    assign ar_chan.size  = AXI_SIZE_WORD;
    assign ar_chan.burst = AXI_BURST_INCR;

    assign aw_chan.id    = ID_DCACHE;
    assign aw_chan.addr  = addr_q;
    assign aw_chan.len   = AXI_LEN_SINGLE;
    assign aw_chan.size  = AXI_SIZE_WORD;
    assign aw_chan.burst = AXI_BURST_INCR;

    assign w_chan.id   = ID_DCACHE;
    assign w_chan.data = wdata_q;
    assign w_chan.strb = wstrb_q;
    assign w_chan.last = 1'b1;  // single beat

    // address beat held with stable fields until taken
    property p_ar_hold;
        @(posedge clk) disable iff (!rst_n)
            arvalid && !arready |=> arvalid && $stable(ar_chan);
    endproperty
    a_ar_hold: assert property (p_ar_hold)
        else $error("arvalid dropped or ar_chan changed before arready");

    a_ar_aw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

    // no data handed to a stalled client
    a_dv_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_data_valid && stall_icache) && !(dcache_data_valid && stall_dcache))
        else $error("data_valid raised during stall");

endmodule

`default_nettype wire

// File: verilog/mem_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_top
    import mem_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       icache_req_valid,
    input  u32_t       icache_pa,
    input  logic       stall_icache,
    output u32_t       icache_data,
    output logic       icache_data_valid,
    output logic       icache_busy,

    input  logic       dcache_req_valid,
    input  logic       dcache_store,
    input  u32_t       dcache_pa,
    input  byte_type_t dcache_byte_type,
    input  u32_t       wr_dcache_data,
    input  logic       stall_dcache,
    output u32_t       rd_dcache_data,
    output logic       dcache_data_valid,
    output logic       dcache_busy,

    output axi_ar_t    ar_chan,
    output logic       arvalid,
    input  logic       arready,
    output axi_aw_t    aw_chan,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w_chan,
    output logic       wvalid,
    input  logic       wready,
    input  axi_r_t     r_chan,
    input  logic       rvalid,
    output logic       rready,
    input  axi_b_t     b_chan,
    input  logic       bvalid,
    output logic       bready
);

    byte_type_t req_byte_type;
    logic [1:0] req_offset;
    u32_t       store_data_raw;
    u32_t       store_word;
    logic [3:0] store_strb;

    assign icache_data = r_chan.data;  // fetches are always full words

    uncached_bridge uncached_bridge_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .icache_req_valid  (icache_req_valid),
        .icache_pa         (icache_pa),
        .stall_icache      (stall_icache),
        .icache_busy       (icache_busy),
        .icache_data_valid (icache_data_valid),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_store      (dcache_store),
        .dcache_pa         (dcache_pa),
        .dcache_byte_type  (dcache_byte_type),
        .wr_dcache_data    (wr_dcache_data),
        .stall_dcache      (stall_dcache),
        .dcache_busy       (dcache_busy),
        .dcache_data_valid (dcache_data_valid),
        .ar_chan           (ar_chan),
        .arvalid           (arvalid),
        .arready           (arready),
        .aw_chan           (aw_chan),
        .awvalid           (awvalid),
        .awready           (awready),
        .w_chan            (w_chan),
        .wvalid            (wvalid),
        .wready            (wready),
        .rvalid            (rvalid),
        .rready            (rready),
        .bvalid            (bvalid),
        .bready            (bready),
        .req_byte_type     (req_byte_type),
        .req_offset        (req_offset),
        .store_data_raw    (store_data_raw),
        .store_word        (store_word),
        .store_strb        (store_strb)
    );

    lane_align lane_align_inst (
        .byte_type  (req_byte_type),
        .offset     (req_offset),
        .store_data (store_data_raw),
        .load_word  (r_chan.data),
        .store_word (store_word),
        .store_strb (store_strb),
        .load_data  (rd_dcache_data)
    );

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // low for two full cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
    import mem_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  axi_ar_t ar_chan,
    input  logic    arvalid,
    output logic    arready,
    input  axi_aw_t aw_chan,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w_chan,
    input  logic    wvalid,
    output logic    wready,
    output axi_r_t  r_chan,
    output logic    rvalid,
    input  logic    rready,
    output axi_b_t  b_chan,
    output logic    bvalid,
    input  logic    bready
);

    localparam int WORDS = 16;

    u32_t       mem [WORDS];
    integer     seed = 32'h17aa;
    logic [3:0] w_idx;   // word picked by the last AW beat
    logic       r_pend;
    logic [1:0] r_wait;
    logic       b_pend;
    logic [1:0] b_wait;

    initial begin
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = u32_t'(a * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            r_pend  <= 1'b0;
            b_pend  <= 1'b0;
            r_wait  <= 2'd0;
            b_wait  <= 2'd0;
            w_idx   <= 4'd0;
            r_chan  <= '0;
            b_chan  <= '0;
        end else begin
            // ready about three cycles in four
            arready <= ($random(seed) & 3) != 0;
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;

            if (arvalid && arready) begin
                r_chan.id   <= ar_chan.id;
                r_chan.data <= mem[ar_chan.addr[5:2]];
                r_chan.resp <= 2'b00;
                r_chan.last <= 1'b1;
                r_wait      <= 2'($random(seed) & 3);
                r_pend      <= 1'b1;
            end else if (r_pend) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    r_pend <= 1'b0;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            if (rvalid && rready) rvalid <= 1'b0;

            if (awvalid && awready) w_idx <= aw_chan.addr[5:2];
            if (wvalid && wready) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_chan.strb[i]) mem[w_idx][8*i +: 8] <= w_chan.data[8*i +: 8];
                end
                b_chan.id   <= w_chan.id;
                b_chan.resp <= 2'b00;
                b_wait      <= 2'($random(seed) & 3);
                b_pend      <= 1'b1;
            end else if (b_pend) begin
                if (b_wait == 2'd0) begin
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import mem_bridge_pkg::*;
();

    localparam int   WAIT_LIMIT = 64;
    localparam u32_t BASE       = 32'h0000_1000;  // 16-word window

    localparam int EV_AR  = 0;
    localparam int EV_AW  = 1;
    localparam int EV_W   = 2;
    localparam int EV_B   = 3;
    localparam int EV_RV  = 4;
    localparam int EV_IDV = 5;
    localparam int EV_DDV = 6;

    logic       clk;
    logic       rst_n;
    logic       icache_req_valid;
    u32_t       icache_pa;
    logic       stall_icache;
    u32_t       icache_data;
    logic       icache_data_valid;
    logic       icache_busy;
    logic       dcache_req_valid;
    logic       dcache_store;
    u32_t       dcache_pa;
    byte_type_t dcache_byte_type;
    u32_t       wr_dcache_data;
    logic       stall_dcache;
    u32_t       rd_dcache_data;
    logic       dcache_data_valid;
    logic       dcache_busy;
    axi_ar_t    ar_chan;
    logic       arvalid;
    logic       arready;
    axi_aw_t    aw_chan;
    logic       awvalid;
    logic       awready;
    axi_w_t     w_chan;
    logic       wvalid;
    logic       wready;
    axi_r_t     r_chan;
    logic       rvalid;
    logic       rready;
    axi_b_t     b_chan;
    logic       bvalid;
    logic       bready;

    integer seed = 32'h17aa;
    u32_t   shadow [16];
    int     n_tests;
    int     n_checks;
    int     n_errors;
    int     checks_at_start;
    int     errors_at_start;
    bit     timed_out;

    clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

    axi_mem_model axi_mem_model_inst (
        .clk(clk), .rst_n(rst_n),
        .ar_chan(ar_chan), .arvalid(arvalid), .arready(arready),
        .aw_chan(aw_chan), .awvalid(awvalid), .awready(awready),
        .w_chan(w_chan), .wvalid(wvalid), .wready(wready),
        .r_chan(r_chan), .rvalid(rvalid), .rready(rready),
        .b_chan(b_chan), .bvalid(bvalid), .bready(bready)
    );

    mem_bridge_top mem_bridge_top_inst (
        .clk(clk), .rst_n(rst_n),
        .icache_req_valid(icache_req_valid), .icache_pa(icache_pa),
        .stall_icache(stall_icache), .icache_data(icache_data),
        .icache_data_valid(icache_data_valid), .icache_busy(icache_busy),
        .dcache_req_valid(dcache_req_valid), .dcache_store(dcache_store),
        .dcache_pa(dcache_pa), .dcache_byte_type(dcache_byte_type),
        .wr_dcache_data(wr_dcache_data), .stall_dcache(stall_dcache),
        .rd_dcache_data(rd_dcache_data), .dcache_data_valid(dcache_data_valid),
        .dcache_busy(dcache_busy),
        .ar_chan(ar_chan), .arvalid(arvalid), .arready(arready),
        .aw_chan(aw_chan), .awvalid(awvalid), .awready(awready),
        .w_chan(w_chan), .wvalid(wvalid), .wready(wready),
        .r_chan(r_chan), .rvalid(rvalid), .rready(rready),
        .b_chan(b_chan), .bvalid(bvalid), .bready(bready)
    );

    task automatic check_word(input string what, input u32_t got, input u32_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED time %0t: %s = %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strb(input string what, input logic [3:0] got, input logic [3:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED time %0t: %s = %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input string what, input logic [3:0] got, input logic [3:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED time %0t: %s = %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED time %0t: %s = %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        n_errors++;
        $display("timeout at time %0t, gave up waiting for %s", $time, what);
    endtask

    // byte placement and extraction rules of the data port
    function automatic logic [3:0] place_strb(input byte_type_t bt, input logic [1:0] off);
        case (bt)
            BT_BYTE, BT_BYTE_U: return 4'b0001 << off;
            BT_HALF, BT_HALF_U: return 4'b0011 << off;
            default:            return 4'b1111;
        endcase
    endfunction

    function automatic u32_t place_data(input byte_type_t bt, input logic [1:0] off, input u32_t d);
        case (bt)
            BT_BYTE, BT_BYTE_U: return {24'd0, d[7:0]} << (8 * off);
            BT_HALF, BT_HALF_U: return {16'd0, d[15:0]} << (8 * off);
            default:            return d;
        endcase
    endfunction

    function automatic u32_t predict_load(input byte_type_t bt, input logic [1:0] off,
                                          input u32_t word);
        u32_t lane;
        lane = word >> (8 * off);
        case (bt)
            BT_BYTE:   return {{24{lane[7]}}, lane[7:0]};
            BT_BYTE_U: return {24'd0, lane[7:0]};
            BT_HALF:   return {{16{lane[15]}}, lane[15:0]};
            BT_HALF_U: return {16'd0, lane[15:0]};
            default:   return word;
        endcase
    endfunction

    function automatic byte_type_t pick_bt(input int k);
        case (k)
            0:       return BT_BYTE;
            1:       return BT_HALF;
            2:       return BT_WORD;
            3:       return BT_BYTE_U;
            default: return BT_HALF_U;
        endcase
    endfunction

    function automatic byte_type_t rand_bt();
        return pick_bt(($random(seed) & 32'h7fff_ffff) % 5);
    endfunction

    // aligned to the access size
    function automatic u32_t rand_addr(input byte_type_t bt);
        u32_t a;
        a = BASE + u32_t'(($random(seed) & 15) << 2);
        if (bt == BT_BYTE || bt == BT_BYTE_U) a[1:0] = 2'($random(seed) & 3);
        if (bt == BT_HALF || bt == BT_HALF_U) a[1] = 1'($random(seed) & 1);
        return a;
    endfunction

    function automatic logic event_seen(input int ev);
        case (ev)
            EV_AR:   return arvalid && arready;
            EV_AW:   return awvalid && awready;
            EV_W:    return wvalid && wready;
            EV_B:    return bvalid && bready;
            EV_RV:   return rvalid;
            EV_IDV:  return icache_data_valid;
            EV_DDV:  return dcache_data_valid;
            default: return 1'b0;
        endcase
    endfunction

    // returns at the rising edge where the event is seen
    task automatic wait_for(input int ev, input string what);
        int n;
        if (timed_out) return;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (event_seen(ev)) return;
        end
        report_timeout(what);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        if (timed_out) return;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (dcache_busy === level) return;
        end
        report_timeout(level ? "dcache_busy to rise" : "dcache_busy to fall");
    endtask

    task automatic wait_reset_release();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (rst_n === 1'b1) return;
        end
        report_timeout("reset release");
    endtask

    task automatic check_idle_outputs();
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("bready", bready, 1'b0);
        check_bit("dcache_busy", dcache_busy, 1'b0);
        check_bit("icache_data_valid", icache_data_valid, 1'b0);
        check_bit("dcache_data_valid", dcache_data_valid, 1'b0);
    endtask

    task automatic do_write(input u32_t addr, input byte_type_t bt, input u32_t data);
        logic [3:0] strb;
        u32_t       placed;
        strb   = place_strb(bt, addr[1:0]);
        placed = place_data(bt, addr[1:0], data);
        if (timed_out) return;
        @(negedge clk);
        dcache_req_valid = 1'b1;
        dcache_store     = 1'b1;
        dcache_pa        = addr;
        dcache_byte_type = bt;
        wr_dcache_data   = data;
        wait_busy(1'b1);
        dcache_req_valid = 1'b0;
        dcache_store     = 1'b0;
        wait_for(EV_AW, "AW beat");
        if (timed_out) return;
        check_word("awaddr", aw_chan.addr, {addr[31:2], 2'b00});
        check_id("awid", aw_chan.id, 4'd1);
        check_word("aw len/size/burst", {19'd0, aw_chan.len, aw_chan.size, aw_chan.burst},
                   {19'd0, 8'd0, 3'd2, 2'd1});
        wait_for(EV_W, "W beat");
        if (timed_out) return;
        check_strb("wstrb", w_chan.strb, strb);
        check_word("wdata", w_chan.data, placed);
        check_id("wid", w_chan.id, 4'd1);
        check_bit("wlast", w_chan.last, 1'b1);
        wait_for(EV_B, "B beat");
        wait_busy(1'b0);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) shadow[addr[5:2]][8*i +: 8] = placed[8*i +: 8];
        end
    endtask

    task automatic do_read(input logic icache, input u32_t addr, input byte_type_t bt,
                           input int stall);
        u32_t got;
        u32_t exp;
        if (timed_out) return;
        @(negedge clk);
        if (icache) begin
            icache_req_valid = 1'b1;
            icache_pa        = addr;
        end else begin
            dcache_req_valid = 1'b1;
            dcache_store     = 1'b0;
            dcache_pa        = addr;
            dcache_byte_type = bt;
        end
        wait_busy(1'b1);
        icache_req_valid = 1'b0;
        dcache_req_valid = 1'b0;
        if (stall > 0) begin
            stall_icache = icache;
            stall_dcache = !icache;
        end
        wait_for(EV_AR, "AR beat");
        if (timed_out) return;
        check_word("araddr", ar_chan.addr, {addr[31:2], 2'b00});
        check_id("arid", ar_chan.id, icache ? 4'd0 : 4'd1);
        check_word("ar len/size/burst", {19'd0, ar_chan.len, ar_chan.size, ar_chan.burst},
                   {19'd0, 8'd0, 3'd2, 2'd1});
        if (stall > 0) begin
            wait_for(EV_RV, "rvalid during stall");
            for (int k = 0; k < stall && !timed_out; k++) begin
                check_bit("rready", rready, 1'b0);
                check_bit("data_valid", icache ? icache_data_valid : dcache_data_valid, 1'b0);
                @(posedge clk);
            end
            @(negedge clk);
            stall_icache = 1'b0;
            stall_dcache = 1'b0;
        end
        wait_for(icache ? EV_IDV : EV_DDV, "data_valid");
        if (timed_out) return;
        got = icache ? icache_data : rd_dcache_data;
        exp = icache ? shadow[addr[5:2]] : predict_load(bt, addr[1:0], shadow[addr[5:2]]);
        check_word(icache ? "icache_data" : "rd_dcache_data", got, exp);
        wait_busy(1'b0);
    endtask

    // both clients ask in the same idle cycle
    task automatic do_dual(input u32_t daddr, input byte_type_t bt, input u32_t iaddr);
        if (timed_out) return;
        @(negedge clk);
        dcache_req_valid = 1'b1;
        dcache_store     = 1'b0;
        dcache_pa        = daddr;
        dcache_byte_type = bt;
        icache_req_valid = 1'b1;
        icache_pa        = iaddr;
        @(posedge clk);
        check_bit("icache_busy at arbitration", icache_busy, 1'b1);  // lost to the data side
        wait_busy(1'b1);
        dcache_req_valid = 1'b0;  // fetch stays pending
        wait_for(EV_AR, "AR beat of the data read");
        if (timed_out) return;
        check_id("arid first", ar_chan.id, 4'd1);
        check_bit("icache_busy", icache_busy, 1'b1);
        wait_for(EV_DDV, "dcache_data_valid");
        if (timed_out) return;
        check_word("rd_dcache_data", rd_dcache_data,
                   predict_load(bt, daddr[1:0], shadow[daddr[5:2]]));
        wait_for(EV_AR, "AR beat of the fetch");
        if (timed_out) return;
        check_id("arid second", ar_chan.id, 4'd0);
        check_word("araddr fetch", ar_chan.addr, {iaddr[31:2], 2'b00});
        @(negedge clk);
        icache_req_valid = 1'b0;
        wait_for(EV_IDV, "icache_data_valid");
        if (timed_out) return;
        check_word("icache_data", icache_data, shadow[iaddr[5:2]]);
        wait_busy(1'b0);
    endtask

    task automatic begin_test();
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %s done: %0d checks, %0d errors", name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
    endtask

    initial begin
        int         k;
        u32_t       a;
        byte_type_t bt;
        icache_req_valid = 1'b0;
        icache_pa        = '0;
        stall_icache     = 1'b0;
        dcache_req_valid = 1'b0;
        dcache_store     = 1'b0;
        dcache_pa        = '0;
        dcache_byte_type = BT_WORD;
        wr_dcache_data   = '0;
        stall_dcache     = 1'b0;
        n_tests   = 0;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;

        begin_test();
        @(posedge clk);
        @(negedge clk);  // still in reset
        check_idle_outputs();
        wait_reset_release();
        check_idle_outputs();
        end_test("reset_state");

        // fills the shadow for every later test
        begin_test();
        for (int i = 0; i < 16; i++) begin
            do_write(BASE + u32_t'(i * 4), BT_WORD, $random(seed));
        end
        repeat (16) do_read(1'b0, rand_addr(BT_WORD), BT_WORD, 0);
        end_test("word_store_load");

        begin_test();
        for (int t = 0; t < 5; t++) begin
            bt = pick_bt(t);
            for (int o = 0; o < 4; o++) begin
                if (bt == BT_WORD && o != 0) continue;
                if ((bt == BT_HALF || bt == BT_HALF_U) && o[0]) continue;
                a = rand_addr(BT_WORD) + u32_t'(o);
                do_write(a, bt, $random(seed));
                do_read(1'b0, {a[31:2], 2'b00}, BT_WORD, 0);
            end
        end
        end_test("subword_store");

        begin_test();
        repeat (30) begin
            bt = rand_bt();
            if (($random(seed) & 3) == 0) do_write(rand_addr(bt), bt, $random(seed));
            bt = rand_bt();
            do_read(1'b0, rand_addr(bt), bt, 0);
        end
        end_test("subword_load");

        begin_test();
        repeat (10) do_read(1'b1, rand_addr(BT_WORD), BT_WORD, 0);
        repeat (4) begin
            bt = rand_bt();
            do_dual(rand_addr(bt), bt, rand_addr(BT_WORD));
        end
        end_test("instruction_fetch");

        begin_test();
        repeat (8) begin
            k  = $random(seed) & 1;
            bt = k ? BT_WORD : rand_bt();
            do_read(k[0], rand_addr(bt), bt, 1 + ($random(seed) & 3));
        end
        end_test("stall_backpressure");

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/mem_bridge_pkg.sv
verilog/lane_align.sv
verilog/uncached_bridge.sv
verilog/mem_bridge_top.sv
bench/clk_gen.sv
bench/axi_mem_model.sv
bench/tb_top.sv
